// ==== rtl/lc4_isa_pkg.sv ====
package lc4_isa_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NZP_W     = 3;

    // instruction field positions
    localparam int OPC_LSB   = 12;
    localparam int OPC_W     = 4;
    localparam int RD_LSB    = 9;
    localparam int RS_LSB    = 6;
    localparam int RT_LSB    = 0;
    localparam int SUBOP_LSB = 3;
    localparam int IMM_BIT   = 5;
    localparam int IMM5_W    = 5;
    localparam int IMM6_W    = 6;
    localparam int IMM9_W    = 9;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    // n in the msb, p in the lsb
    typedef logic [NZP_W-1:0]     nzp_t;

    typedef enum logic [OPC_W-1:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM,
        ALU_ADDR,
        ALU_BR_TARGET
    } alu_op_e;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     regfile_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        alu_op_e  alu_op;
    } ctrl_t;

    // sign class of a value written to the register file
    function automatic nzp_t nzp_of(word_t value);
        if (value[WORD_W-1]) begin
            return 3'b100;
        end
        if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

endpackage

// ==== rtl/lc4_pipe_pkg.sv ====
package lc4_pipe_pkg;

    localparam lc4_isa_pkg::word_t RESET_PC = 16'h8200;

    typedef enum logic [1:0] {
        STALL_NONE   = 2'd0,
        // pipe-switch stall of a two-pipe core, never raised here
        STALL_PIPE   = 2'd1,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_e;

    typedef struct packed {
        lc4_isa_pkg::word_t pc;
        lc4_isa_pkg::word_t insn;
        lc4_isa_pkg::ctrl_t ctrl;
        lc4_isa_pkg::word_t rs_data;
        lc4_isa_pkg::word_t rt_data;
        stall_e             stall;
    } stage_t;

    // one register-file write, as seen by a bypass
    typedef struct packed {
        logic                  we;
        lc4_isa_pkg::reg_sel_t sel;
        lc4_isa_pkg::word_t    data;
    } fwd_t;

    typedef struct packed {
        lc4_isa_pkg::word_t    pc;
        lc4_isa_pkg::word_t    insn;
        stall_e                stall;
        logic                  regfile_we;
        lc4_isa_pkg::reg_sel_t regfile_wsel;
        lc4_isa_pkg::word_t    regfile_data;
        logic                  nzp_we;
        lc4_isa_pkg::nzp_t     nzp_bits;
        logic                  dmem_we;
        lc4_isa_pkg::word_t    dmem_addr;
        lc4_isa_pkg::word_t    dmem_data;
    } trace_t;

    // empty slot with no control bits set
    function automatic stage_t stage_bubble(stall_e kind);
        stage_t s;
        s       = '0;
        s.stall = kind;
        return s;
    endfunction

    function automatic trace_t trace_idle();
        trace_t t;
        t       = '0;
        t.stall = STALL_BRANCH;
        return t;
    endfunction

endpackage

// ==== rtl/lc4_regfile.sv ====
`timescale 1ns/10ps

module lc4_regfile (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    input  lc4_isa_pkg::reg_sel_t i_rs,
    input  lc4_isa_pkg::reg_sel_t i_rt,
    input  lc4_isa_pkg::reg_sel_t i_wsel,
    input  logic                  i_we,
    input  lc4_isa_pkg::word_t    i_wdata,
    output lc4_isa_pkg::word_t    o_rs_data,
    output lc4_isa_pkg::word_t    o_rt_data
);
    import lc4_isa_pkg::*;

    word_t regs [2**REG_SEL_W];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**REG_SEL_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // writeback in this cycle is visible to decode right away
    assign o_rs_data = (i_we && i_wsel == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_wsel == i_rt) ? i_wdata : regs[i_rt];

endmodule

// ==== rtl/lc4_decode.sv ====
`timescale 1ns/10ps

module lc4_decode (
    input  logic                 gwe,
    input  logic                 i_arst_n,
    input  lc4_isa_pkg::word_t   i_insn,
    input  logic                 i_redirect,
    input  lc4_isa_pkg::word_t   i_redirect_pc,
    input  lc4_pipe_pkg::stage_t i_x_view,
    input  lc4_pipe_pkg::fwd_t   i_w_fwd,
    output lc4_isa_pkg::word_t   o_pc,
    output lc4_pipe_pkg::stage_t o_d2x
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    word_t  pc_q;
    word_t  d_pc;
    word_t  d_insn;
    stall_e d_stall;
    ctrl_t  dec;
    ctrl_t  ctrl;
    word_t  rs_data;
    word_t  rt_data;
    logic   load_use;
    logic   hold;

    always_comb begin
        dec    = '0;
        dec.rd = d_insn[RD_LSB +: REG_SEL_W];
        dec.rs = d_insn[RS_LSB +: REG_SEL_W];
        dec.rt = d_insn[RT_LSB +: REG_SEL_W];
        case (opcode_e'(d_insn[OPC_LSB +: OPC_W]))
            OP_BR: begin
                dec.is_branch = 1'b1;
                dec.alu_op    = ALU_BR_TARGET;
            end
            OP_ARITH: begin
                dec.rs_re      = 1'b1;
                dec.rt_re      = !d_insn[IMM_BIT];
                dec.regfile_we = 1'b1;
                dec.nzp_we     = 1'b1;
                dec.alu_op     = (d_insn[SUBOP_LSB +: 3] == 3'b010) ? ALU_SUB : ALU_ADD;
            end
            OP_LOGIC: begin
                dec.rs_re      = 1'b1;
                dec.rt_re      = !d_insn[IMM_BIT];
                dec.regfile_we = 1'b1;
                dec.nzp_we     = 1'b1;
                case (d_insn[SUBOP_LSB +: 3])
                    3'b010:  dec.alu_op = ALU_OR;
                    3'b011:  dec.alu_op = ALU_XOR;
                    default: dec.alu_op = ALU_AND;
                endcase
            end
            OP_LDR: begin
                dec.rs_re      = 1'b1;
                dec.regfile_we = 1'b1;
                dec.nzp_we     = 1'b1;
                dec.is_load    = 1'b1;
                dec.alu_op     = ALU_ADDR;
            end
            OP_STR: begin
                // store data register sits in the rd field
                dec.rt       = d_insn[RD_LSB +: REG_SEL_W];
                dec.rs_re    = 1'b1;
                dec.rt_re    = 1'b1;
                dec.is_store = 1'b1;
                dec.alu_op   = ALU_ADDR;
            end
            OP_CONST: begin
                dec.regfile_we = 1'b1;
                dec.nzp_we     = 1'b1;
                dec.alu_op     = ALU_PASS_IMM;
            end
            default: ;
        endcase
    end

    assign ctrl = (d_stall == STALL_NONE) ? dec : '0;

    // stored data of a STR is served by the WM bypass instead
    // a conditional branch also waits for the NZP bits of the load
    assign load_use = i_x_view.ctrl.is_load &&
                      ((ctrl.rs_re && ctrl.rs == i_x_view.ctrl.rd) ||
                       (ctrl.rt_re && !ctrl.is_store && ctrl.rt == i_x_view.ctrl.rd) ||
                       (ctrl.is_branch && |d_insn[RD_LSB +: NZP_W]));
    assign hold = load_use && !i_redirect;

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs      (ctrl.rs),
        .i_rt      (ctrl.rt),
        .i_wsel    (i_w_fwd.sel),
        .i_we      (i_w_fwd.we),
        .i_wdata   (i_w_fwd.data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q    <= RESET_PC;
            d_stall <= STALL_BRANCH;
        end else if (i_redirect) begin
            pc_q    <= i_redirect_pc;
            d_stall <= STALL_BRANCH;
        end else if (!hold) begin
            pc_q    <= pc_q + 1'b1;
            d_stall <= STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_redirect && !hold) begin
            d_pc   <= pc_q;
            d_insn <= i_insn;
        end
    end

    always_comb begin
        if (i_redirect) begin
            o_d2x = stage_bubble(STALL_BRANCH);
        end else if (load_use) begin
            o_d2x = stage_bubble(STALL_LOAD);
        end else if (d_stall != STALL_NONE) begin
            o_d2x = stage_bubble(d_stall);
        end else begin
            o_d2x = '{pc: d_pc, insn: d_insn, ctrl: ctrl, rs_data: rs_data,
                      rt_data: rt_data, stall: STALL_NONE};
        end
    end

    assign o_pc = pc_q;

    // a taken branch in execute is never a load, so no load-use hold meets a flush
    a_redirect_no_hold: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_redirect |-> !load_use);

endmodule

// ==== rtl/lc4_execute.sv ====
`timescale 1ns/10ps

module lc4_execute (
    input  logic                 gwe,
    input  logic                 i_arst_n,
    input  lc4_pipe_pkg::stage_t i_d2x,
    input  lc4_pipe_pkg::fwd_t   i_m_fwd,
    input  lc4_pipe_pkg::fwd_t   i_w_fwd,
    output lc4_pipe_pkg::stage_t o_x_view,
    output lc4_pipe_pkg::stage_t o_x2m,
    output logic                 o_redirect,
    output lc4_isa_pkg::word_t   o_redirect_pc
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    stage_t x_q;
    word_t  rs_val;
    word_t  rt_val;
    word_t  op_b;
    word_t  imm5;
    word_t  imm6;
    word_t  imm9;
    word_t  alu_res;
    nzp_t   nzp_q;
    nzp_t   nzp_eff;
    nzp_t   cond;
    logic   m_ld;
    logic   w_ld;
    logic   m_nzw;
    logic   ld_pending;
    logic   taken;

    // memory stage is younger than writeback, so it wins
    function automatic word_t bypass(reg_sel_t sel, word_t reg_val, fwd_t m, fwd_t w);
        if (m.we && m.sel == sel) begin
            return m.data;
        end
        if (w.we && w.sel == sel) begin
            return w.data;
        end
        return reg_val;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_q <= stage_bubble(STALL_BRANCH);
        end else begin
            x_q <= i_d2x;
        end
    end

    assign rs_val = bypass(x_q.ctrl.rs, x_q.rs_data, i_m_fwd, i_w_fwd);
    assign rt_val = bypass(x_q.ctrl.rt, x_q.rt_data, i_m_fwd, i_w_fwd);

    assign imm5 = {{(WORD_W-IMM5_W){x_q.insn[IMM5_W-1]}}, x_q.insn[IMM5_W-1:0]};
    assign imm6 = {{(WORD_W-IMM6_W){x_q.insn[IMM6_W-1]}}, x_q.insn[IMM6_W-1:0]};
    assign imm9 = {{(WORD_W-IMM9_W){x_q.insn[IMM9_W-1]}}, x_q.insn[IMM9_W-1:0]};
    assign op_b = x_q.ctrl.rt_re ? rt_val : imm5;

    always_comb begin
        case (x_q.ctrl.alu_op)
            ALU_ADD:       alu_res = rs_val + op_b;
            ALU_SUB:       alu_res = rs_val - op_b;
            ALU_AND:       alu_res = rs_val & op_b;
            ALU_OR:        alu_res = rs_val | op_b;
            ALU_XOR:       alu_res = rs_val ^ op_b;
            ALU_PASS_IMM:  alu_res = imm9;
            ALU_ADDR:      alu_res = rs_val + imm6;
            ALU_BR_TARGET: alu_res = x_q.pc + 1'b1 + imm9;
            default:       alu_res = '0;
        endcase
    end

    // loads write NZP from writeback, so track them down the pipe
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= '0;
            m_ld  <= 1'b0;
            w_ld  <= 1'b0;
            m_nzw <= 1'b0;
        end else begin
            m_ld  <= x_q.ctrl.is_load;
            w_ld  <= m_ld;
            m_nzw <= x_q.ctrl.nzp_we && !x_q.ctrl.is_load;
            if (x_q.ctrl.nzp_we && !x_q.ctrl.is_load) begin
                nzp_q <= nzp_of(alu_res);
            end else if (ld_pending) begin
                nzp_q <= nzp_of(i_w_fwd.data);
            end
        end
    end

    // a load in writeback is the newest NZP writer unless an ALU op followed it
    assign ld_pending = w_ld && !m_nzw;
    assign nzp_eff    = ld_pending ? nzp_of(i_w_fwd.data) : nzp_q;
    assign cond       = x_q.insn[RD_LSB +: NZP_W];
    assign taken      = x_q.ctrl.is_branch && |(cond & nzp_eff);

    assign o_redirect    = taken;
    assign o_redirect_pc = alu_res;
    assign o_x_view      = x_q;
    assign o_x2m         = '{pc: x_q.pc, insn: x_q.insn, ctrl: x_q.ctrl, rs_data: alu_res,
                             rt_data: rt_val, stall: x_q.stall};

    // only a real branch redirects, and the slot behind it arrives flushed
    a_no_bubble_redirect: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_redirect |-> (x_q.stall == STALL_NONE) ##1 (x_q.stall == STALL_BRANCH));

endmodule

// ==== rtl/lc4_result.sv ====
`timescale 1ns/10ps

module lc4_result (
    input  logic                 gwe,
    input  logic                 i_arst_n,
    input  lc4_pipe_pkg::stage_t i_x2m,
    input  lc4_isa_pkg::word_t   i_dmem_rdata,
    output lc4_isa_pkg::word_t   o_dmem_addr,
    output logic                 o_dmem_we,
    output lc4_isa_pkg::word_t   o_dmem_wdata,
    output lc4_pipe_pkg::fwd_t   o_m_fwd,
    output lc4_pipe_pkg::fwd_t   o_w_fwd,
    output lc4_pipe_pkg::trace_t o_trace
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    stage_t m_q;
    trace_t w_q;
    trace_t w_d;
    word_t  st_data;
    word_t  wb_data;
    logic   mem_access;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_q <= stage_bubble(STALL_BRANCH);
            w_q <= trace_idle();
        end else begin
            m_q <= i_x2m;
            w_q <= w_d;
        end
    end

    assign mem_access = m_q.ctrl.is_load || m_q.ctrl.is_store;

    // WM bypass of store data from the instruction now in writeback
    assign st_data = (w_q.regfile_we && w_q.regfile_wsel == m_q.ctrl.rt) ?
                     w_q.regfile_data : m_q.rt_data;
    assign wb_data = m_q.ctrl.is_load ? i_dmem_rdata : m_q.rs_data;

    assign o_dmem_addr  = mem_access ? m_q.rs_data : '0;
    assign o_dmem_we    = m_q.ctrl.is_store;
    assign o_dmem_wdata = st_data;

    // a load never forwards from here, decode holds its consumer back
    assign o_m_fwd = '{we: m_q.ctrl.regfile_we && !m_q.ctrl.is_load,
                       sel: m_q.ctrl.rd, data: m_q.rs_data};

    always_comb begin
        w_d.pc           = m_q.pc;
        w_d.insn         = m_q.insn;
        w_d.stall        = m_q.stall;
        w_d.regfile_we   = m_q.ctrl.regfile_we;
        w_d.regfile_wsel = m_q.ctrl.rd;
        w_d.regfile_data = wb_data;
        w_d.nzp_we       = m_q.ctrl.nzp_we;
        w_d.nzp_bits     = nzp_of(wb_data);
        w_d.dmem_we      = m_q.ctrl.is_store;
        w_d.dmem_addr    = o_dmem_addr;
        if (m_q.ctrl.is_load) begin
            w_d.dmem_data = i_dmem_rdata;
        end else if (m_q.ctrl.is_store) begin
            w_d.dmem_data = st_data;
        end else begin
            w_d.dmem_data = '0;
        end
    end

    assign o_trace = w_q;
    assign o_w_fwd = '{we: w_q.regfile_we, sel: w_q.regfile_wsel, data: w_q.regfile_data};

    // memory writes come only from a decoded STR
    a_dmem_we_store: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_dmem_we |-> (opcode_e'(m_q.insn[OPC_LSB +: OPC_W]) == OP_STR) &&
        (m_q.stall == STALL_NONE));

endmodule

// ==== rtl/lc4_core.sv ====
`timescale 1ns/10ps

module lc4_core (
    input  logic                 gwe,
    input  logic                 i_arst_n,
    input  lc4_isa_pkg::word_t   i_imem_insn,
    input  lc4_isa_pkg::word_t   i_dmem_rdata,
    output lc4_isa_pkg::word_t   o_imem_addr,
    output lc4_isa_pkg::word_t   o_dmem_addr,
    output logic                 o_dmem_we,
    output lc4_isa_pkg::word_t   o_dmem_wdata,
    output lc4_pipe_pkg::trace_t o_trace
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    stage_t d2x;
    stage_t x_view;
    stage_t x2m;
    fwd_t   m_fwd;
    fwd_t   w_fwd;
    logic   redirect;
    word_t  redirect_pc;

    // fetch and decode
    lc4_decode u_decode (
        .gwe           (gwe),
        .i_arst_n      (i_arst_n),
        .i_insn        (i_imem_insn),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_x_view      (x_view),
        .i_w_fwd       (w_fwd),
        .o_pc          (o_imem_addr),
        .o_d2x         (d2x)
    );

    lc4_execute u_execute (
        .gwe           (gwe),
        .i_arst_n      (i_arst_n),
        .i_d2x         (d2x),
        .i_m_fwd       (m_fwd),
        .i_w_fwd       (w_fwd),
        .o_x_view      (x_view),
        .o_x2m         (x2m),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    // memory and writeback
    lc4_result u_result (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_x2m        (x2m),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .o_m_fwd      (m_fwd),
        .o_w_fwd      (w_fwd),
        .o_trace      (o_trace)
    );

endmodule

// ==== sim/tb_lc4_programs.svh ====
`ifndef TB_LC4_PROGRAMS_SVH
`define TB_LC4_PROGRAMS_SVH

function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic word_t const_insn(reg_sel_t rd, logic [8:0] imm);
    return {4'b1001, rd, imm};
endfunction

function automatic word_t rrr_insn(logic [3:0] opc, logic [2:0] sub, reg_sel_t rd,
                                   reg_sel_t rs, reg_sel_t rt);
    return {opc, rd, rs, sub, rt};
endfunction

function automatic word_t addi_insn(reg_sel_t rd, reg_sel_t rs, logic [4:0] imm);
    return {4'b0001, rd, rs, 1'b1, imm};
endfunction

function automatic word_t ldr_insn(reg_sel_t rd, reg_sel_t rs, logic [5:0] off);
    return {4'b0110, rd, rs, off};
endfunction

function automatic word_t str_insn(reg_sel_t rt, reg_sel_t rs, logic [5:0] off);
    return {4'b0111, rt, rs, off};
endfunction

function automatic word_t br_insn(nzp_t cond, logic [8:0] off);
    return {4'b0000, cond, off};
endfunction

// places program id at the reset PC and returns how many instructions it retires
task automatic load_program(input int id, output int n_retire);
    word_t       p[$];
    logic [31:0] x;
    int          k;
    int          a;
    p = {};
    case (id)
        0: begin
            p = {br_insn(3'b000, 9'd0), br_insn(3'b000, 9'd0)};
            n_retire = 4;
        end
        1: begin
            x = 32'd83246;
            for (k = 0; k < 4; k++) begin
                p.push_back(const_insn(3'(k), 9'(k * 37 + 11)));
            end
            // four registers only, so dependences land at distance 1 to 3
            for (k = 0; k < 16; k++) begin
                x = xorshift(x);
                case (x[10:8])
                    3'd0: p.push_back(rrr_insn(4'b0001, 3'b000, {1'b0, x[1:0]},
                                               {1'b0, x[3:2]}, {1'b0, x[5:4]}));
                    3'd1: p.push_back(rrr_insn(4'b0001, 3'b010, {1'b0, x[1:0]},
                                               {1'b0, x[3:2]}, {1'b0, x[5:4]}));
                    3'd2: p.push_back(rrr_insn(4'b0101, 3'b000, {1'b0, x[1:0]},
                                               {1'b0, x[3:2]}, {1'b0, x[5:4]}));
                    3'd3: p.push_back(rrr_insn(4'b0101, 3'b010, {1'b0, x[1:0]},
                                               {1'b0, x[3:2]}, {1'b0, x[5:4]}));
                    3'd4: p.push_back(rrr_insn(4'b0101, 3'b011, {1'b0, x[1:0]},
                                               {1'b0, x[3:2]}, {1'b0, x[5:4]}));
                    3'd5: p.push_back(addi_insn({1'b0, x[1:0]}, {1'b0, x[3:2]}, x[16:12]));
                    default: p.push_back(const_insn({1'b0, x[1:0]}, x[20:12]));
                endcase
            end
            n_retire = 20;
        end
        2: begin
            p = {const_insn(3'd2, 9'h040), ldr_insn(3'd1, 3'd2, 6'd3),
                 rrr_insn(4'b0001, 3'b000, 3'd3, 3'd1, 3'd2)};
            n_retire = 3;
        end
        3: begin
            p = {const_insn(3'd0, 9'd1), br_insn(3'b001, 9'd2), const_insn(3'd1, 9'd5),
                 const_insn(3'd1, 9'd6), br_insn(3'b100, 9'd1), br_insn(3'b000, 9'd0),
                 const_insn(3'd2, 9'd7)};
            n_retire = 5;
        end
        4: begin
            p = {const_insn(3'd2, 9'h050), ldr_insn(3'd1, 3'd2, 6'd0),
                 str_insn(3'd1, 3'd2, 6'd8), ldr_insn(3'd4, 3'd2, 6'd8)};
            n_retire = 4;
        end
        default: begin
            p = {const_insn(3'd2, 9'h060), const_insn(3'd1, 9'h1fd), str_insn(3'd1, 3'd2, 6'd0),
                 const_insn(3'd1, 9'd0), str_insn(3'd1, 3'd2, 6'd1), const_insn(3'd1, 9'd9),
                 str_insn(3'd1, 3'd2, 6'd2), ldr_insn(3'd3, 3'd2, 6'd0), br_insn(3'b100, 9'd1),
                 const_insn(3'd5, 9'd1), ldr_insn(3'd3, 3'd2, 6'd1), br_insn(3'b010, 9'd1),
                 const_insn(3'd5, 9'd2), ldr_insn(3'd3, 3'd2, 6'd2), br_insn(3'b001, 9'd1),
                 const_insn(3'd5, 9'd3), const_insn(3'd6, 9'd4)};
            n_retire = 14;
        end
    endcase
    for (a = 0; a < 256; a++) begin
        imem[RESET_PC + word_t'(a)] = '0;
    end
    foreach (p[i]) begin
        imem[RESET_PC + word_t'(i)] = p[i];
    end
endtask

`endif

// ==== sim/tb_lc4_core.sv ====
`timescale 1ns/10ps

module tb_lc4_core;
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    localparam int N_TESTS = 6;

    logic     gwe;
    logic     i_arst_n;
    word_t    i_imem_insn;
    word_t    i_dmem_rdata;
    word_t    o_imem_addr;
    word_t    o_dmem_addr;
    logic     o_dmem_we;
    word_t    o_dmem_wdata;
    trace_t   o_trace;
    word_t    imem [65536];
    word_t    dmem [65536];
    // architectural model state
    word_t    m_regs [8];
    word_t    m_mem [65536];
    nzp_t     m_nzp;
    word_t    m_pc;
    logic     m_prev_valid;
    logic     m_prev_taken;
    logic     m_prev_load;
    reg_sel_t m_prev_rd;
    int       n_br;
    int       n_ld;
    int       retired;
    int       post_rst;
    int       cycles;
    int       limit;
    int       errors;
    int       passed;
    // expected fields of the entry now on the trace
    logic     e_we;
    word_t    e_data;
    logic     e_nzp_we;
    logic     e_dmem_we;
    logic     e_mem_chk;
    word_t    e_addr;
    word_t    e_mdata;
    logic     e_taken;
    logic     e_ld_bub;
    logic     e_load;
    word_t    e_next_pc;
    logic     retire;

    `include "tb_lc4_programs.svh"

    lc4_core i_dut (
        .gwe          (gwe),
        .i_arst_n     (i_arst_n),
        .i_imem_insn  (i_imem_insn),
        .i_dmem_rdata (i_dmem_rdata),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .o_trace      (o_trace)
    );

    assign i_imem_insn  = imem[o_imem_addr];
    assign i_dmem_rdata = dmem[o_dmem_addr];
    assign retire       = (o_trace.stall == STALL_NONE);

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr] <= o_dmem_wdata;
        end
    end

    function automatic nzp_t sign_bits(word_t v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == 16'h0000) ? 3'b010 : 3'b001;
    endfunction

    function automatic word_t fill_word(int a);
        word_t w;
        w = word_t'(a);
        return (w * 16'h9e37) ^ (w >> 5);
    endfunction

    // ISA rules applied to the instruction on the trace
    always_comb begin
        word_t    insn;
        word_t    a;
        word_t    b;
        reg_sel_t rd;
        reg_sel_t rs;
        reg_sel_t rt;
        logic     reads_rs;
        logic     reads_rt;
        insn      = o_trace.insn;
        rd        = insn[11:9];
        rs        = insn[8:6];
        rt        = insn[2:0];
        a         = m_regs[rs];
        b         = insn[5] ? {{11{insn[4]}}, insn[4:0]} : m_regs[rt];
        e_we      = 1'b0;
        e_data    = '0;
        e_nzp_we  = 1'b0;
        e_dmem_we = 1'b0;
        e_load    = 1'b0;
        e_addr    = a + {{10{insn[5]}}, insn[5:0]};
        e_mdata   = '0;
        e_taken   = 1'b0;
        e_next_pc = o_trace.pc + 16'd1;
        reads_rs  = 1'b1;
        reads_rt  = !insn[5];
        case (opcode_e'(insn[15:12]))
            OP_ARITH: begin
                e_data = (insn[5:3] == 3'b010) ? a - b : a + b;
            end
            OP_LOGIC: begin
                case (insn[5:3])
                    3'b010:  e_data = a | b;
                    3'b011:  e_data = a ^ b;
                    default: e_data = a & b;
                endcase
            end
            OP_CONST: begin
                e_data   = {{7{insn[8]}}, insn[8:0]};
                reads_rs = 1'b0;
                reads_rt = 1'b0;
            end
            OP_LDR: begin
                e_load   = 1'b1;
                e_data   = m_mem[e_addr];
                e_mdata  = e_data;
                reads_rt = 1'b0;
            end
            OP_STR: begin
                e_dmem_we = 1'b1;
                e_mdata   = m_regs[rd];
                reads_rt  = 1'b0;
            end
            default: begin
                reads_rs = 1'b0;
                reads_rt = 1'b0;
                e_taken  = |(rd & m_nzp);
                if (e_taken) begin
                    e_next_pc = o_trace.pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
                end
            end
        endcase
        e_we      = !e_dmem_we && opcode_e'(insn[15:12]) != OP_BR;
        e_nzp_we  = e_we;
        e_mem_chk = e_load || e_dmem_we;
        // a branch with condition bits waits for the NZP of a load too
        e_ld_bub  = m_prev_load && ((reads_rs && rs == m_prev_rd) ||
                    (reads_rt && rt == m_prev_rd) ||
                    (opcode_e'(insn[15:12]) == OP_BR && rd != 3'b000));
    end

    always @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int r = 0; r < 8; r++) begin
                m_regs[r] <= '0;
            end
            m_nzp        <= '0;
            m_pc         <= RESET_PC;
            m_prev_valid <= 1'b0;
            m_prev_load  <= 1'b0;
            m_prev_taken <= 1'b0;
            m_prev_rd    <= '0;
            n_br         <= 0;
            n_ld         <= 0;
            retired      <= 0;
            post_rst     <= 0;
        end else begin
            post_rst <= post_rst + 1;
            if (retire) begin
                if (e_we) begin
                    m_regs[o_trace.insn[11:9]] <= e_data;
                    m_nzp                      <= sign_bits(e_data);
                end
                if (e_dmem_we) begin
                    m_mem[e_addr] <= e_mdata;
                end
                m_pc         <= e_next_pc;
                m_prev_valid <= 1'b1;
                m_prev_taken <= e_taken;
                m_prev_load  <= e_load;
                m_prev_rd    <= o_trace.insn[11:9];
                n_br         <= 0;
                n_ld         <= 0;
                retired      <= retired + 1;
            end else if (o_trace.stall == STALL_BRANCH) begin
                n_br <= n_br + 1;
            end else if (o_trace.stall == STALL_LOAD) begin
                n_ld <= n_ld + 1;
            end
        end
    end

    task automatic flag_mismatch(string field);
        errors++;
        $display("mismatch at %0t: trace %s differs from model, pc %h", $time, field,
                 o_trace.pc);
    endtask

    a_pc: assert property (@(posedge gwe) disable iff (!i_arst_n)
        retire |-> o_trace.pc == m_pc) else flag_mismatch("pc");
    a_wb: assert property (@(posedge gwe) disable iff (!i_arst_n)
        retire |-> o_trace.regfile_we == e_we && (!e_we ||
        (o_trace.regfile_wsel == o_trace.insn[11:9] && o_trace.regfile_data == e_data)))
        else flag_mismatch("register write");
    a_nzp: assert property (@(posedge gwe) disable iff (!i_arst_n)
        retire |-> o_trace.nzp_we == e_nzp_we &&
        (!e_nzp_we || o_trace.nzp_bits == sign_bits(e_data)))
        else flag_mismatch("nzp bits");
    a_mem: assert property (@(posedge gwe) disable iff (!i_arst_n)
        retire |-> o_trace.dmem_we == e_dmem_we && (!e_mem_chk ||
        (o_trace.dmem_addr == e_addr && o_trace.dmem_data == e_mdata)))
        else flag_mismatch("data memory access");
    a_bubbles: assert property (@(posedge gwe) disable iff (!i_arst_n)
        retire && m_prev_valid |-> n_br == (m_prev_taken ? 2 : 0) &&
        n_ld == (e_ld_bub ? 1 : 0)) else flag_mismatch("bubble count");
    a_quiet: assert property (@(posedge gwe) disable iff (!i_arst_n)
        !retire |-> !o_trace.regfile_we && !o_trace.nzp_we && !o_trace.dmem_we &&
        o_trace.stall != STALL_PIPE) else flag_mismatch("bubble write flags");
    a_idle: assert property (@(posedge gwe) disable iff (!i_arst_n)
        post_rst < 4 |-> o_trace.stall == STALL_BRANCH && !o_dmem_we)
        else flag_mismatch("idle after reset");

    initial begin
        gwe = 1'b0;
        forever #10 gwe = ~gwe;
    end

    always @(posedge gwe) begin
        if (i_arst_n) begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge gwe);
        end
        $display("timeout: the tests did not retire all instructions in %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    task automatic run_test(input int id, input string name);
        int n;
        int err0;
        err0 = errors;
        @(posedge gwe);
        #2;
        i_arst_n = 1'b0;
        load_program(id, n);
        repeat (8) @(posedge gwe);
        #2;
        i_arst_n = 1'b1;
        while (retired < n) begin
            @(posedge gwe);
        end
        @(posedge gwe);
        if (errors == err0) begin
            passed++;
        end
        $display("test %0d %s: %s", id, name, (errors == err0) ? "ok" : "errors seen");
    endtask

    initial begin
        int n;
        int total;
        i_arst_n = 1'b0;
        errors   = 0;
        passed   = 0;
        cycles   = 0;
        limit    = 0;
        total    = 0;
        for (int a = 0; a < 65536; a++) begin
            imem[a]  = '0;
            dmem[a]  = fill_word(a);
            m_mem[a] = fill_word(a);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            load_program(t, n);
            total += n;
        end
        limit = total * 3 + 50;
        run_test(0, "reset");
        run_test(1, "alu bypass");
        run_test(2, "load use");
        run_test(3, "branches");
        run_test(4, "stores");
        run_test(5, "nzp on loads");
        $display("tests: %0d passed, %0d failed, %0d mismatches", passed, N_TESTS - passed,
                 errors);
        if (errors == 0 && passed == N_TESTS) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== lc4_core.f ====
+incdir+sim
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_regfile.sv
rtl/lc4_decode.sv
rtl/lc4_execute.sv
rtl/lc4_result.sv
rtl/lc4_core.sv
sim/tb_lc4_core.sv

// ==== Bender.yml ====
package:
  name: lc4_core

sources:
  - rtl/lc4_isa_pkg.sv
  - rtl/lc4_pipe_pkg.sv
  - rtl/lc4_regfile.sv
  - rtl/lc4_decode.sv
  - rtl/lc4_execute.sv
  - rtl/lc4_result.sv
  - rtl/lc4_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_lc4_core.sv
